/* include/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_WORD_W      32              // data and pc width
`define CPU_REG_N       32              // architectural registers
`define CPU_REG_AW      5               // register index width
`define CPU_RESET_PC    32'h0040_0000   // first fetch address
`define CPU_PC_STEP     4               // one word per instruction

// instruction field positions
`define CPU_OP_HI       31
`define CPU_OP_LO       26
`define CPU_RS_HI       25
`define CPU_RS_LO       21
`define CPU_RT_HI       20
`define CPU_RT_LO       16
`define CPU_RD_HI       15
`define CPU_RD_LO       11
`define CPU_FN_HI       5
`define CPU_FN_LO       0
`define CPU_IMM_HI      15
`define CPU_IMM_LO      0
`define CPU_IMM_W       16              // immediate width before extension

`endif

/* verilog/cpu_pkg.sv */
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    typedef enum logic [5:0]
    {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_ori   = 6'h0D
    } opcode_e;

    typedef enum logic [5:0]
    {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_e;

    // codes kept from the five-stage core
    typedef enum logic [2:0]
    {
        exc_none       = 3'd0,
        exc_illegal    = 3'd1,
        exc_overflow   = 3'd2,
        exc_zero_write = 3'd7
    } exc_cause_e;

    typedef struct packed
    {
        logic       valid;
        word_t      pc;
        alu_op_e    alu_op;
        word_t      operand_a;      // rs value
        word_t      operand_b;      // rt value or extended immediate
        logic       check_overflow; // add, sub, addi
        logic       writes_reg;
        reg_addr_t  dest;
        exc_cause_e cause;
    } decoded_t;

    typedef struct packed
    {
        logic       valid;
        word_t      pc;
        logic       writes_reg;
        reg_addr_t  dest;
        word_t      result;
        exc_cause_e cause;
    } executed_t;

    typedef struct packed
    {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } forward_t;

    typedef struct packed
    {
        logic       valid;
        word_t      pc;
        reg_addr_t  dest;
        word_t      data;
        logic       writes_reg;     // set only when the register file was written
        exc_cause_e cause;
    } commit_t;

endpackage

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

`include "cpu_cfg.svh"

module reg_file
(
    input  wire                SYS_clk,
    input  wire                SYS_reset,
    input  wire cpu_pkg::reg_addr_t rd_addr_a,
    input  wire cpu_pkg::reg_addr_t rd_addr_b,
    output cpu_pkg::word_t     rd_data_a,
    output cpu_pkg::word_t     rd_data_b,
    input  wire cpu_pkg::forward_t  write
);
    import cpu_pkg::*;

    word_t regs [`CPU_REG_N];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `CPU_REG_N; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (write.valid)
        begin
            regs[write.dest] <= write.data;
        end
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];  // r0 hardwired
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

    // zero writes are stopped in the result stage before they get here
    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        write.valid |-> (write.dest != '0))
        else $error("register file write to r0");

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

`include "cpu_cfg.svh"

module decode_stage
(
    input  wire                    SYS_clk,
    input  wire                    SYS_reset,
    input  wire                    instr_valid,
    input  wire cpu_pkg::word_t    instr,
    input  wire cpu_pkg::forward_t ex_forward,
    input  wire cpu_pkg::forward_t wb_forward,
    output cpu_pkg::decoded_t      decoded
);
    import cpu_pkg::*;

    logic                  instr_q_valid;
    word_t                 instr_q;
    word_t                 pc_q;
    word_t                 pc_cnt;
    opcode_e               opcode;
    funct_e                funct;
    reg_addr_t             rs;
    reg_addr_t             rt;
    reg_addr_t             rd;
    logic [`CPU_IMM_W-1:0] imm;
    word_t                 imm_ext;
    word_t                 rs_value;
    word_t                 rt_value;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  sign_ext;
    logic                  dest_is_rd;
    logic                  illegal;

    // youngest producer wins, r0 never forwarded
    function automatic word_t pick_operand(reg_addr_t addr, word_t rf_data,
                                           forward_t ex_fwd, forward_t wb_fwd);
        word_t value;
        if (addr == '0)
            value = '0;
        else if (ex_fwd.valid && (ex_fwd.dest == addr))
            value = ex_fwd.data;
        else if (wb_fwd.valid && (wb_fwd.dest == addr))
            value = wb_fwd.data;
        else
            value = rf_data;
        return value;
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            instr_q_valid <= 1'b0;
            instr_q       <= '0;
            pc_q          <= '0;
            pc_cnt        <= `CPU_RESET_PC;
        end
        else
        begin
            instr_q_valid <= instr_valid;
            if (instr_valid)
            begin
                instr_q <= instr;
                pc_q    <= pc_cnt;
                pc_cnt  <= pc_cnt + `CPU_PC_STEP;  // counts accepted instructions only
            end
        end
    end

    assign opcode = opcode_e'(instr_q[`CPU_OP_HI:`CPU_OP_LO]);
    assign funct  = funct_e'(instr_q[`CPU_FN_HI:`CPU_FN_LO]);
    assign rs     = instr_q[`CPU_RS_HI:`CPU_RS_LO];
    assign rt     = instr_q[`CPU_RT_HI:`CPU_RT_LO];
    assign rd     = instr_q[`CPU_RD_HI:`CPU_RD_LO];
    assign imm    = instr_q[`CPU_IMM_HI:`CPU_IMM_LO];

    always_comb
    begin
        alu_op     = alu_add;
        use_imm    = 1'b0;
        sign_ext   = 1'b1;
        dest_is_rd = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            op_rtype:
            begin
                dest_is_rd = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: illegal = 1'b1;  // unknown funct
                endcase
            end
            op_addi: use_imm = 1'b1;
            op_ori:
            begin
                alu_op   = alu_or;
                use_imm  = 1'b1;
                sign_ext = 1'b0;  // ori takes a zero-extended immediate
            end
            default: illegal = 1'b1;  // unknown opcode
        endcase
    end

    assign imm_ext = sign_ext ? {{(`CPU_WORD_W-`CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm}
                              : {{(`CPU_WORD_W-`CPU_IMM_W){1'b0}}, imm};

    reg_file i_reg_file
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rd_addr_a (rs),
        .rd_addr_b (rt),
        .rd_data_a (rs_value),
        .rd_data_b (rt_value),
        .write     (wb_forward)
    );

    always_comb
    begin
        decoded.valid          = instr_q_valid;
        decoded.pc             = pc_q;
        decoded.alu_op         = alu_op;
        decoded.operand_a      = pick_operand(rs, rs_value, ex_forward, wb_forward);
        decoded.operand_b      = use_imm ? imm_ext
                                         : pick_operand(rt, rt_value, ex_forward, wb_forward);
        decoded.check_overflow = (alu_op == alu_add) || (alu_op == alu_sub);
        decoded.writes_reg     = !illegal;
        decoded.dest           = dest_is_rd ? rd : rt;
        decoded.cause          = illegal ? exc_illegal : exc_none;
    end

    a_instr_known: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        instr_valid |-> !$isunknown(instr))
        else $error("instruction has unknown bits while valid");

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`default_nettype none

`include "cpu_cfg.svh"

module execute_stage
(
    input  wire                    SYS_clk,
    input  wire                    SYS_reset,
    input  wire cpu_pkg::decoded_t decoded,
    output cpu_pkg::executed_t     executed,
    output cpu_pkg::forward_t      ex_forward
);
    import cpu_pkg::*;

    localparam int SIGN = `CPU_WORD_W - 1;

    decoded_t   dec_q;
    word_t      a;
    word_t      b;
    word_t      result;
    logic       ovf_flag;
    logic       overflow;
    exc_cause_e cause;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            dec_q <= '0;
        else
            dec_q <= decoded;
    end

    assign a = dec_q.operand_a;
    assign b = dec_q.operand_b;

    always_comb
    begin
        result   = '0;
        ovf_flag = 1'b0;
        case (dec_q.alu_op)
            alu_add:
            begin
                result   = a + b;
                ovf_flag = (a[SIGN] == b[SIGN]) && (result[SIGN] != a[SIGN]);
            end
            alu_sub:
            begin
                result   = a - b;
                ovf_flag = (a[SIGN] != b[SIGN]) && (result[SIGN] != a[SIGN]);
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = word_t'($signed(a) < $signed(b));
            default: result = '0;
        endcase
    end

    assign overflow = dec_q.check_overflow && ovf_flag;  // and/or/slt never trap

    always_comb
    begin
        if (dec_q.cause != exc_none)
            cause = dec_q.cause;  // earlier fault has priority
        else if (overflow)
            cause = exc_overflow;
        else
            cause = exc_none;
    end

    always_comb
    begin
        executed.valid      = dec_q.valid;
        executed.pc         = dec_q.pc;
        executed.writes_reg = dec_q.writes_reg;
        executed.dest       = dec_q.dest;
        executed.result     = result;
        executed.cause      = cause;
    end

    // back to decode for the next instruction
    assign ex_forward.valid = dec_q.valid && dec_q.writes_reg && (cause == exc_none);
    assign ex_forward.dest  = dec_q.dest;
    assign ex_forward.data  = result;

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`default_nettype none

module result_stage
(
    input  wire                     SYS_clk,
    input  wire                     SYS_reset,
    input  wire cpu_pkg::executed_t executed,
    output cpu_pkg::forward_t       wb_forward,
    output cpu_pkg::commit_t        commit,
    output cpu_pkg::word_t          epc
);
    import cpu_pkg::*;

    executed_t  exe_q;
    logic       zero_write;
    exc_cause_e cause;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            exe_q <= '0;
        else
            exe_q <= executed;
    end

    assign zero_write = exe_q.writes_reg && (exe_q.dest == '0);

    always_comb
    begin
        if (exe_q.cause != exc_none)
            cause = exe_q.cause;
        else if (zero_write)
            cause = exc_zero_write;
        else
            cause = exc_none;
    end

    always_comb
    begin
        commit.valid      = exe_q.valid;
        commit.pc         = exe_q.pc;
        commit.dest       = exe_q.dest;
        commit.data       = exe_q.result;
        commit.writes_reg = exe_q.writes_reg && (cause == exc_none);  // faults never write
        commit.cause      = cause;
    end

    assign wb_forward.valid = exe_q.valid && commit.writes_reg;  // also the rf write enable
    assign wb_forward.dest  = exe_q.dest;
    assign wb_forward.data  = exe_q.result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            epc <= '0;
        else if (commit.valid && (cause != exc_none))
            epc <= exe_q.pc;  // latest fault
    end

    a_wb_no_cause: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_forward.valid |-> (commit.cause == exc_none))
        else $error("register write from a faulting instruction");

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`default_nettype none

module cpu_core
(
    input  wire                 SYS_clk,
    input  wire                 SYS_reset,
    input  wire                 instr_valid,
    input  wire cpu_pkg::word_t instr,
    output cpu_pkg::commit_t    commit,
    output cpu_pkg::word_t      epc
);
    import cpu_pkg::*;

    decoded_t  decoded;
    executed_t executed;
    forward_t  ex_forward;   // alu result, one instruction back
    forward_t  wb_forward;   // result stage, two back, also writes the rf

    decode_stage i_decode_stage
    (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex_forward  (ex_forward),
        .wb_forward  (wb_forward),
        .decoded     (decoded)
    );

    execute_stage i_execute_stage
    (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .decoded    (decoded),
        .executed   (executed),
        .ex_forward (ex_forward)
    );

    result_stage i_result_stage
    (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .executed   (executed),
        .wb_forward (wb_forward),
        .commit     (commit),
        .epc        (epc)
    );

endmodule

`default_nettype wire

/* verif/cpu_core_tb.sv */
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int PERIOD       = 40;
    localparam int CHAIN_LEN    = 60;
    localparam int DIRECTED_LEN = 29;
    localparam int N_INSTR      = CHAIN_LEN + DIRECTED_LEN;

    logic    SYS_clk;
    logic    SYS_reset;
    logic    instr_valid;
    word_t   instr;
    commit_t commit;
    word_t   epc;

    word_t   model_regs [`CPU_REG_N];  // architectural state
    word_t   model_pc;
    word_t   model_epc;
    int      n_illegal;
    int      n_overflow;
    int      n_zero_write;
    integer  seed = 81;
    commit_t exp_commit_q [$];
    word_t   exp_epc_q [$];

    cpu_core i_cpu_core
    (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .commit      (commit),
        .epc         (epc)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) SYS_clk = ~SYS_clk;
        end
    end

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, word_t got, word_t exp);
        $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
        stop_with_failure("value mismatch at a DUT output");
    endtask

    task automatic check_commit(commit_t got, commit_t exp);
        if (got.pc !== exp.pc)
            report_mismatch("commit.pc", got.pc, exp.pc);
        else if (got.cause !== exp.cause)
            report_mismatch("commit.cause", word_t'(got.cause), word_t'(exp.cause));
        else if (got.writes_reg !== exp.writes_reg)
            report_mismatch("commit.writes_reg", word_t'(got.writes_reg), word_t'(exp.writes_reg));
        else if (got.dest !== exp.dest)
            report_mismatch("commit.dest", word_t'(got.dest), word_t'(exp.dest));
        else if (exp.writes_reg && (got.data !== exp.data))
            report_mismatch("commit.data", got.data, exp.data);  // only real writes carry data
    endtask

    task automatic check_epc(word_t got, word_t exp);
        if (got !== exp)
            report_mismatch("epc", got, exp);
    endtask

    function automatic word_t encode_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                       reg_addr_t rd);
        word_t w;
        w = '0;
        w[`CPU_OP_HI:`CPU_OP_LO] = op_rtype;
        w[`CPU_RS_HI:`CPU_RS_LO] = rs;
        w[`CPU_RT_HI:`CPU_RT_LO] = rt;
        w[`CPU_RD_HI:`CPU_RD_LO] = rd;
        w[`CPU_FN_HI:`CPU_FN_LO] = fn;
        return w;
    endfunction

    function automatic word_t encode_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                       logic [`CPU_IMM_W-1:0] imm);
        word_t w;
        w = '0;
        w[`CPU_OP_HI:`CPU_OP_LO]   = op;
        w[`CPU_RS_HI:`CPU_RS_LO]   = rs;
        w[`CPU_RT_HI:`CPU_RT_LO]   = rt;
        w[`CPU_IMM_HI:`CPU_IMM_LO] = imm;
        return w;
    endfunction

    // one instruction through the architectural model
    function automatic commit_t model_step(word_t ins);
        commit_t                   e;
        logic [5:0]                op;
        logic [5:0]                fn;
        word_t                     a;
        word_t                     b;
        word_t                     data;
        logic signed [`CPU_WORD_W:0] wide;
        logic                      known;
        logic                      trap;
        op    = ins[`CPU_OP_HI:`CPU_OP_LO];
        fn    = ins[`CPU_FN_HI:`CPU_FN_LO];
        a     = model_regs[ins[`CPU_RS_HI:`CPU_RS_LO]];
        b     = model_regs[ins[`CPU_RT_HI:`CPU_RT_LO]];
        e     = '0;
        data  = '0;
        wide  = '0;
        known = 1'b1;
        trap  = 1'b0;
        e.valid = 1'b1;
        e.pc    = model_pc;
        e.dest  = ins[`CPU_RT_HI:`CPU_RT_LO];
        model_pc = model_pc + `CPU_PC_STEP;
        if (op == op_rtype)
        begin
            e.dest = ins[`CPU_RD_HI:`CPU_RD_LO];
            case (fn)
                fn_add:  wide = $signed({a[`CPU_WORD_W-1], a}) + $signed({b[`CPU_WORD_W-1], b});
                fn_sub:  wide = $signed({a[`CPU_WORD_W-1], a}) - $signed({b[`CPU_WORD_W-1], b});
                fn_and:  data = a & b;
                fn_or:   data = a | b;
                fn_slt:  data = ($signed(a) < $signed(b)) ? 1 : 0;
                default: known = 1'b0;
            endcase
            if ((fn == fn_add) || (fn == fn_sub))
            begin
                data = wide[`CPU_WORD_W-1:0];
                trap = wide[`CPU_WORD_W] != wide[`CPU_WORD_W-1];  // sign bits disagree
            end
        end
        else if (op == op_addi)
        begin
            b    = {{(`CPU_WORD_W-`CPU_IMM_W){ins[`CPU_IMM_HI]}}, ins[`CPU_IMM_HI:`CPU_IMM_LO]};
            wide = $signed({a[`CPU_WORD_W-1], a}) + $signed({b[`CPU_WORD_W-1], b});
            data = wide[`CPU_WORD_W-1:0];
            trap = wide[`CPU_WORD_W] != wide[`CPU_WORD_W-1];
        end
        else if (op == op_ori)
            data = a | {{(`CPU_WORD_W-`CPU_IMM_W){1'b0}}, ins[`CPU_IMM_HI:`CPU_IMM_LO]};
        else
            known = 1'b0;
        if (!known)
            e.cause = exc_illegal;
        else if (trap)
            e.cause = exc_overflow;
        else if (e.dest == '0)
            e.cause = exc_zero_write;
        else
            e.cause = exc_none;
        n_illegal    += (e.cause == exc_illegal);
        n_overflow   += (e.cause == exc_overflow);
        n_zero_write += (e.cause == exc_zero_write);
        e.writes_reg = (e.cause == exc_none);
        e.data       = data;
        if (e.writes_reg)
            model_regs[e.dest] = data;
        else
            model_epc = e.pc;  // latest fault
        return e;
    endfunction

    task automatic issue(word_t ins);
        @(posedge SYS_clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        exp_commit_q.push_back(model_step(ins));
        exp_epc_q.push_back(model_epc);
    endtask

    task automatic idle();
        @(posedge SYS_clk);
        instr_valid <= 1'b0;
    endtask

    // random dependent chain, each one reads the previous destination
    task automatic run_chain();
        reg_addr_t prev;
        reg_addr_t rd;
        reg_addr_t other;
        int        kind;
        prev = 5'd1;
        for (int i = 0; i < CHAIN_LEN; i++)
        begin
            kind  = {$random(seed)} % 7;
            rd    = 1 + ({$random(seed)} % 31);
            other = {$random(seed)} % 32;
            case (kind)
                0: issue(encode_r(fn_add, prev, other, rd));
                1: issue(encode_r(fn_sub, other, prev, rd));
                2: issue(encode_r(fn_and, prev, other, rd));
                3: issue(encode_r(fn_or, other, prev, rd));
                4: issue(encode_r(fn_slt, prev, other, rd));
                5: issue(encode_i(op_addi, prev, rd, $random(seed)));
                default: issue(encode_i(op_ori, prev, rd, $random(seed)));
            endcase
            prev = rd;
            if (({$random(seed)} % 4) == 0)
                idle();  // gap with no commit
        end
    endtask

    task automatic run_directed();
        issue(encode_i(op_addi, 5'd0, 5'd5, 16'h8000));
        for (int i = 0; i < 16; i++)
        begin
            issue(encode_r(fn_add, 5'd5, 5'd5, 5'd5));  // doubles up to 0x80000000
        end
        issue(encode_r(fn_add, 5'd5, 5'd5, 5'd6));
        issue(encode_r(fn_sub, 5'd0, 5'd5, 5'd7));
        issue(encode_i(op_addi, 5'd5, 5'd8, 16'hffff));
        issue(encode_r(fn_or, 5'd6, 5'd7, 5'd9));
        issue(encode_i(op_ori, 5'd0, 5'd10, 16'h1234));
        issue(encode_i(op_ori, 5'd0, 5'd11, 16'h5678));
        issue(encode_i(6'h3f, 5'd10, 5'd10, 16'h00ff));  // unknown opcode
        issue(encode_r(6'h00, 5'd11, 5'd11, 5'd11));     // unknown funct
        issue(encode_r(fn_or, 5'd10, 5'd11, 5'd12));
        issue(encode_i(op_addi, 5'd12, 5'd0, 16'h0005));
        issue(encode_r(fn_or, 5'd12, 5'd12, 5'd0));
        issue(encode_r(fn_add, 5'd0, 5'd12, 5'd13));
    endtask

    initial
    begin
        SYS_reset    = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        model_pc     = `CPU_RESET_PC;
        model_epc    = '0;
        n_illegal    = 0;
        n_overflow   = 0;
        n_zero_write = 0;
        for (int i = 0; i < `CPU_REG_N; i++)
        begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        repeat (2) idle();
        run_chain();
        run_directed();
        idle();
        while (exp_commit_q.size() != 0)
        begin
            @(posedge SYS_clk);
        end
        repeat (3) @(negedge SYS_clk);  // last epc check and no stray commit
        if ((n_illegal == 0) || (n_overflow == 0) || (n_zero_write == 0))
        begin
            stop_with_failure("a fault case was never exercised");
        end
        else
        begin
            $display("** PASS **");
            $finish;
        end
    end

    initial
    begin : compare
        commit_t exp_c;
        word_t   epc_expect;
        epc_expect = '0;
        @(negedge SYS_reset);
        forever
        begin
            @(negedge SYS_clk);
            check_epc(epc, epc_expect);
            if (commit.valid)
            begin
                if (exp_commit_q.size() == 0)
                begin
                    stop_with_failure("commit appeared with no expected instruction");
                end
                else
                begin
                    exp_c      = exp_commit_q.pop_front();
                    epc_expect = exp_epc_q.pop_front();  // seen from the next cycle on
                    check_commit(commit, exp_c);
                end
            end
        end
    end

    initial
    begin
        #((N_INSTR * 3 + 20) * PERIOD);
        stop_with_failure("watchdog timeout, the pipeline did not drain in time");
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/cpu_core.sv
verif/cpu_core_tb.sv
